/* verilog/ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// control flow encodings of the machine-mode controller
// fetch address select, vector kind and FSM states
////////////////////////////////////////////////////////////

package ctrl_pkg;

  // source of the next fetch address, valid only with pc_set
  typedef enum logic [1:0] {
    PC_BOOT = 2'b00,
    PC_JUMP = 2'b01,
    PC_EXC  = 2'b10,
    PC_ERET = 2'b11
  } pc_sel_e;

  // which vector the exception PC mux points at
  typedef enum logic {
    EXC_PC_IRQ = 1'b0,
    EXC_PC_EXC = 1'b1
  } exc_pc_sel_e;

  // sequencing FSM states, all eight codes in use
  typedef enum logic [2:0] {
    RESET       = 3'd0,
    BOOT_SET    = 3'd1,
    FIRST_FETCH = 3'd2,
    DECODE      = 3'd3,
    FLUSH       = 3'd4,
    IRQ_TAKEN   = 3'd5,
    WAIT_SLEEP  = 3'd6,
    SLEEP       = 3'd7
  } ctrl_state_e;

endpackage

/* verilog/trap_pkg.sv */
////////////////////////////////////////////////////////////
// trap related types: data word, privilege, trap cause
////////////////////////////////////////////////////////////

package trap_pkg;

  // instructions, PCs and trap values
  typedef logic [31:0] word_t;

  // one bit per fast interrupt line
  typedef logic [15:0] fast_irq_t;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // bit 6 set means interrupt, bit 5 set on top of it means NMI
  typedef enum logic [6:0] {
    EXC_CAUSE_INSN_ADDR_MISA     = 7'h00,
    EXC_CAUSE_INSTR_ACCESS_FAULT = 7'h01,
    EXC_CAUSE_ILLEGAL_INSN       = 7'h02,
    EXC_CAUSE_BREAKPOINT         = 7'h03,
    EXC_CAUSE_ECALL_UMODE        = 7'h08,
    EXC_CAUSE_ECALL_MMODE        = 7'h0B,
    EXC_CAUSE_IRQ_SOFTWARE_M     = 7'h43,
    EXC_CAUSE_IRQ_TIMER_M        = 7'h47,
    EXC_CAUSE_IRQ_EXTERNAL_M     = 7'h4B,
    EXC_CAUSE_IRQ_FAST_0         = 7'h50,
    EXC_CAUSE_IRQ_NM             = 7'h60
  } exc_cause_e;

endpackage

/* verilog/trap_detect.sv */
////////////////////////////////////////////////////////////
// exception request qualification and prioritisation
// registers the requests and picks cause and trap value
////////////////////////////////////////////////////////////

module trap_detect
  import trap_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,

  // decoder flags, not yet qualified with instr_valid_i
  input  logic       instr_valid_i,
  input  logic       illegal_insn_i,
  input  logic       ecall_insn_i,
  input  logic       ebrk_insn_i,
  input  logic       mret_insn_i,
  input  logic       wfi_insn_i,
  input  logic       csr_pipe_flush_i,
  input  logic       instr_fetch_err_i,
  input  word_t      instr_i,
  input  word_t      pc_id_i,

  // CSR state
  input  priv_lvl_e  priv_mode_i,
  input  logic       csr_mstatus_tw_i,

  // high while the FSM is in flush
  input  logic       in_flush_i,

  output logic       mret_o,
  output logic       wfi_o,
  output logic       special_req_o,
  output logic       exc_pending_o,
  output exc_cause_e exc_cause_o,
  output word_t      exc_mtval_o
);

  logic ecall_insn;
  logic ebrk_insn;
  logic fetch_err;
  logic pipe_flush;
  logic illegal_umode;
  logic illegal_insn_d, illegal_insn_q;
  logic exc_req_d, exc_req_q;

  // decoder does not look at instr_valid, factor it in here
  assign ecall_insn = ecall_insn_i & instr_valid_i;
  assign ebrk_insn  = ebrk_insn_i & instr_valid_i;
  assign fetch_err  = instr_fetch_err_i & instr_valid_i;
  assign pipe_flush = csr_pipe_flush_i & instr_valid_i;
  assign mret_o     = mret_insn_i & instr_valid_i;
  assign wfi_o      = wfi_insn_i & instr_valid_i;

  // mret needs M-mode, wfi too when mstatus.tw traps it
  assign illegal_umode = (priv_mode_i != PRIV_LVL_M) &
                         (mret_o | (csr_mstatus_tw_i & wfi_o));

  // flush clears the requests so a handled one does not linger
  assign illegal_insn_d = ((illegal_insn_i & instr_valid_i) | illegal_umode) & ~in_flush_i;
  assign exc_req_d      = (ecall_insn | ebrk_insn | illegal_insn_d | fetch_err) & ~in_flush_i;

  // anything that sends the FSM through flush
  assign special_req_o = mret_o | wfi_o | pipe_flush | exc_req_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_insn_q <= 1'b0;
      exc_req_q      <= 1'b0;
    end else begin
      illegal_insn_q <= illegal_insn_d;
      exc_req_q      <= exc_req_d;
    end
  end

  assign exc_pending_o = exc_req_q;

  // fixed priority: fetch fault, illegal, ecall, ebreak
  always_comb begin
    exc_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    exc_mtval_o = '0;
    if (fetch_err) begin
      exc_cause_o = EXC_CAUSE_INSTR_ACCESS_FAULT;
      exc_mtval_o = pc_id_i;
    end else if (illegal_insn_q) begin
      exc_cause_o = EXC_CAUSE_ILLEGAL_INSN;
      exc_mtval_o = instr_i;
    end else if (ecall_insn) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE :
                                                  EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk_insn) begin
      // no debug mode, ebreak always traps
      exc_cause_o = EXC_CAUSE_BREAKPOINT;
    end
  end

endmodule

/* verilog/irq_arbiter.sv */
////////////////////////////////////////////////////////////
// interrupt arbitration and cause encoding
// also tracks whether the NMI handler is running
////////////////////////////////////////////////////////////

module irq_arbiter
  import trap_pkg::*;
#(
  parameter int unsigned NrFastIrq = 16
) (
  input  logic       clk_i,
  input  logic       rst_ni,

  input  logic       irq_pending_i,
  input  logic       csr_mstatus_mie_i,
  input  logic       irq_nm_i,
  input  fast_irq_t  irq_fast_i,
  input  logic       irq_external_i,
  input  logic       irq_software_i,
  input  logic       irq_timer_i,

  // strobes from the FSM
  input  logic       irq_enter_i,
  input  logic       mret_done_i,

  output logic       take_irq_o,
  output logic       wake_o,
  output exc_cause_e irq_cause_o,
  output logic       nmi_mode_o
);

  // lines at or above NrFastIrq are not wired
  localparam fast_irq_t FastMask = fast_irq_t'((32'd1 << NrFastIrq) - 32'd1);

  fast_irq_t fast_irq;
  logic [3:0] fast_id;
  logic       nmi_mode_q;

  assign fast_irq = irq_fast_i & FastMask;

  // no nesting inside the NMI handler, not even another NMI
  assign take_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending_i & csr_mstatus_mie_i));
  assign wake_o     = irq_nm_i | irq_pending_i;

  // lowest numbered fast line wins
  always_comb begin
    fast_id = 4'd0;
    for (int i = 15; i >= 0; i--) begin
      if (fast_irq[i]) begin
        fast_id = i[3:0];
      end
    end
  end

  always_comb begin
    irq_cause_o = EXC_CAUSE_INSN_ADDR_MISA;
    if (irq_nm_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_NM;
    end else if (fast_irq != '0) begin
      // fast line n maps to 0x50 + n
      irq_cause_o = exc_cause_e'(EXC_CAUSE_IRQ_FAST_0 | {3'b000, fast_id});
    end else if (irq_external_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irq_software_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else if (irq_timer_i) begin
      irq_cause_o = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // set when the NMI is entered, cleared by mret
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (irq_enter_i && (irq_cause_o == EXC_CAUSE_IRQ_NM)) begin
      nmi_mode_q <= 1'b1;
    end else if (mret_done_i) begin
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule

/* verilog/ctrl_fsm.sv */
////////////////////////////////////////////////////////////
// main sequencing FSM of the controller
// drives fetch, PC select, CSR save strobes and ID control
////////////////////////////////////////////////////////////

module ctrl_fsm
  import ctrl_pkg::*;
  import trap_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        fetch_enable_i,
  input  logic        instr_valid_i,
  input  logic        stall_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,

  // from trap_detect
  input  logic        mret_i,
  input  logic        wfi_i,
  input  logic        special_req_i,
  input  logic        exc_pending_i,
  input  exc_cause_e  exc_cause_i,
  input  word_t       exc_mtval_i,

  // from irq_arbiter
  input  logic        take_irq_i,
  input  logic        wake_i,
  input  exc_cause_e  irq_cause_i,

  // back to the helper blocks
  output logic        in_flush_o,
  output logic        irq_enter_o,
  output logic        mret_done_o,

  output logic        ctrl_busy_o,
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output exc_cause_e  exc_cause_o,
  output logic        csr_save_if_o,
  output logic        csr_save_id_o,
  output logic        csr_restore_mret_id_o,
  output logic        csr_save_cause_o,
  output word_t       csr_mtval_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o
);

  ctrl_state_e state_q, state_d;

  // halt IF, keep the ID instruction, or kill it
  logic halt_if;
  logic retain_id;
  logic flush_id;

  ////////////////////////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d               = state_q;
    instr_req_o           = 1'b1;
    ctrl_busy_o           = 1'b1;
    pc_set_o              = 1'b0;
    // mux values only matter with pc_set
    pc_mux_o              = PC_BOOT;
    exc_pc_mux_o          = EXC_PC_IRQ;
    exc_cause_o           = EXC_CAUSE_INSN_ADDR_MISA;
    csr_save_if_o         = 1'b0;
    csr_save_id_o         = 1'b0;
    csr_restore_mret_id_o = 1'b0;
    csr_save_cause_o      = 1'b0;
    csr_mtval_o           = '0;
    irq_enter_o           = 1'b0;
    mret_done_o           = 1'b0;
    halt_if               = 1'b0;
    retain_id             = 1'b0;
    flush_id              = 1'b0;

    unique case (state_q)
      RESET: begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i) begin
          state_d = BOOT_SET;
        end
      end
      BOOT_SET: begin
        // load boot address into the fetch stage
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end
      FIRST_FETCH: begin
        // wait here on an IF miss
        if (!stall_id_i) begin
          state_d = DECODE;
        end
      end
      DECODE: begin
        pc_mux_o = PC_JUMP;
        // keep the instruction in ID, flush decides what to do with it
        if (special_req_i) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end
        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end
        // let the ID instruction finish before the interrupt goes in
        if (take_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end
        if (take_irq_i && !stall_id_i && !special_req_i && !instr_valid_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end
      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;
        if (exc_pending_i) begin
          // trap: vector to handler, save ID PC, cause and trap value
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          exc_pc_mux_o     = EXC_PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc_cause_i;
          csr_mtval_o      = exc_mtval_i;
        end else if (mret_i) begin
          pc_set_o              = 1'b1;
          pc_mux_o              = PC_ERET;
          csr_restore_mret_id_o = 1'b1;
          mret_done_o           = 1'b1;
        end else if (wfi_i) begin
          state_d = WAIT_SLEEP;
        end
      end
      IRQ_TAKEN: begin
        halt_if      = 1'b1;
        pc_mux_o     = PC_EXC;
        exc_pc_mux_o = EXC_PC_IRQ;
        // line may have dropped since decode
        if (take_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq_cause_i;
          irq_enter_o      = 1'b1;
        end
        state_d = DECODE;
      end
      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end
      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        // clock stays gated until something wakes the core
        if (wake_i) begin
          state_d = FIRST_FETCH;
        end else begin
          ctrl_busy_o = 1'b0;
        end
      end
      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // stall control and state register
  ////////////////////////////////////////////////////////////

  assign in_flush_o = (state_q == FLUSH);
  assign flush_id_o = flush_id;

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain keeps instr_valid set, a flush always clears it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* verilog/core_ctrl.sv */
////////////////////////////////////////////////////////////
// machine-mode controller top
// chains trap detection, interrupt arbitration and the FSM
////////////////////////////////////////////////////////////

module core_ctrl
  import ctrl_pkg::*;
  import trap_pkg::*;
#(
  parameter int unsigned NrFastIrq = 16
) (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        fetch_enable_i,
  output logic        ctrl_busy_o,

  // decoder and IF-ID register
  input  logic        instr_valid_i,
  input  logic        illegal_insn_i,
  input  logic        ecall_insn_i,
  input  logic        ebrk_insn_i,
  input  logic        mret_insn_i,
  input  logic        wfi_insn_i,
  input  logic        csr_pipe_flush_i,
  input  logic        instr_fetch_err_i,
  input  word_t       instr_i,
  input  word_t       pc_id_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,

  // CSR state and interrupt lines
  input  priv_lvl_e   priv_mode_i,
  input  logic        csr_mstatus_tw_i,
  input  logic        csr_mstatus_mie_i,
  input  logic        irq_pending_i,
  input  logic        irq_nm_i,
  input  fast_irq_t   irq_fast_i,
  input  logic        irq_external_i,
  input  logic        irq_software_i,
  input  logic        irq_timer_i,
  output logic        nmi_mode_o,

  // fetch and ID stage control
  output logic        instr_req_o,
  output logic        pc_set_o,
  output pc_sel_e     pc_mux_o,
  output exc_pc_sel_e exc_pc_mux_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,

  // CSR updates
  output exc_cause_e  exc_cause_o,
  output logic        csr_save_if_o,
  output logic        csr_save_id_o,
  output logic        csr_restore_mret_id_o,
  output logic        csr_save_cause_o,
  output word_t       csr_mtval_o
);

  // trap_detect to FSM
  logic       mret;
  logic       wfi;
  logic       special_req;
  logic       exc_pending;
  exc_cause_e exc_cause;
  word_t      exc_mtval;

  // irq_arbiter to FSM
  logic       take_irq;
  logic       wake;
  exc_cause_e irq_cause;

  // FSM back to the helpers
  logic       in_flush;
  logic       irq_enter;
  logic       mret_done;

  trap_detect u_trap_detect (
    .*,
    .in_flush_i   (in_flush),
    .mret_o       (mret),
    .wfi_o        (wfi),
    .special_req_o(special_req),
    .exc_pending_o(exc_pending),
    .exc_cause_o  (exc_cause),
    .exc_mtval_o  (exc_mtval)
  );

  irq_arbiter #(
    .NrFastIrq(NrFastIrq)
  ) u_irq_arbiter (
    .*,
    .irq_enter_i(irq_enter),
    .mret_done_i(mret_done),
    .take_irq_o (take_irq),
    .wake_o     (wake),
    .irq_cause_o(irq_cause)
  );

  ctrl_fsm u_ctrl_fsm (
    .*,
    .mret_i       (mret),
    .wfi_i        (wfi),
    .special_req_i(special_req),
    .exc_pending_i(exc_pending),
    .exc_cause_i  (exc_cause),
    .exc_mtval_i  (exc_mtval),
    .take_irq_i   (take_irq),
    .wake_i       (wake),
    .irq_cause_i  (irq_cause),
    .in_flush_o   (in_flush),
    .irq_enter_o  (irq_enter),
    .mret_done_o  (mret_done)
  );

endmodule

/* test/ctrl_checker.sv */
////////////////////////////////////////////////////////////
// result checker of the controller testbench
// compares DUT outputs with trace values each cycle
////////////////////////////////////////////////////////////

module ctrl_checker
  import ctrl_pkg::*;
  import trap_pkg::*;
(
  input  logic        clk_i,
  input  logic        valid_i,
  input  logic        done_i,
  input  int          test_i,
  input  logic        fetch_enable_i,
  input  logic        stall_id_i,

  // expected values from the trace
  input  logic        exp_pc_set_i,
  input  logic [1:0]  exp_pc_mux_i,
  input  logic [6:0]  exp_cause_i,
  input  logic [31:0] exp_mtval_i,
  input  logic        exp_busy_i,
  input  logic        exp_save_cause_i,

  // observed DUT signals
  input  logic        pc_set_i,
  input  pc_sel_e     pc_mux_i,
  input  exc_pc_sel_e exc_pc_mux_i,
  input  exc_cause_e  exc_cause_i,
  input  word_t       csr_mtval_i,
  input  logic        ctrl_busy_i,
  input  logic        instr_req_i,
  input  logic        csr_save_if_i,
  input  logic        csr_save_id_i,
  input  logic        csr_restore_mret_i,
  input  logic        csr_save_cause_i,
  input  logic        id_in_ready_i,
  input  logic        instr_valid_clear_i,
  input  logic        flush_id_i,
  input  logic        nmi_mode_i,

  output int          err_count_o
);

  timeunit 1ns;
  timeprecision 100ps;

  int   cur_test = -1;
  int   test_errs = 0;
  int   tests_ok = 0;
  int   tests_bad = 0;
  int   errs = 0;
  logic summary_done = 1'b0;

  // reference state carried over from earlier rows
  logic fetch_on = 1'b0;
  logic boot_next = 1'b0;
  logic nmi_exp = 1'b0;

  // kind of row, taken from the expected outputs
  logic irq_trap;
  logic exc_trap;
  logic mret_ret;

  assign err_count_o = errs;

  // interrupt causes carry bit 6
  assign irq_trap = exp_save_cause_i & exp_cause_i[6];
  assign exc_trap = exp_save_cause_i & ~exp_cause_i[6];
  assign mret_ret = exp_pc_set_i & (exp_pc_mux_i == PC_ERET);

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("ERR test %0d %s expected %h actual %h", cur_test, name, exp_v, act_v);
      test_errs++;
      errs++;
    end
  endtask

  // one summary line for the test just completed
  task automatic close_test();
    if (cur_test >= 0) begin
      if (test_errs == 0) begin
        $display("test %0d passed", cur_test);
        tests_ok++;
      end else begin
        $display("test %0d failed with %0d mismatches", cur_test, test_errs);
        tests_bad++;
      end
    end
  endtask

  // inputs settle 2 ns after the edge, sample mid cycle
  always @(negedge clk_i) begin
    if (valid_i) begin
      if (test_i != cur_test) begin
        close_test();
        cur_test  = test_i;
        test_errs = 0;
      end
      compare_value("pc_set_o", 32'(exp_pc_set_i), 32'(pc_set_i));
      compare_value("pc_mux_o", 32'(exp_pc_mux_i), 32'(pc_mux_i));
      compare_value("exc_cause_o", 32'(exp_cause_i), 32'(exc_cause_i));
      compare_value("csr_mtval_o", exp_mtval_i, csr_mtval_i);
      compare_value("ctrl_busy_o", 32'(exp_busy_i), 32'(ctrl_busy_i));
      compare_value("csr_save_cause_o", 32'(exp_save_cause_i), 32'(csr_save_cause_i));
      // no fetch before fetch enable is sampled, boot set fetches
      if (!fetch_on) begin
        compare_value("instr_req_o", 32'd0, 32'(instr_req_i));
      end else if (boot_next) begin
        compare_value("instr_req_o", 32'd1, 32'(instr_req_i));
      end
      // interrupts take the IRQ vector, exceptions the exception vector
      if (exp_pc_set_i && (exp_pc_mux_i == PC_EXC)) begin
        compare_value("exc_pc_mux_o", irq_trap ? 32'(EXC_PC_IRQ) : 32'(EXC_PC_EXC),
                      32'(exc_pc_mux_i));
      end
      compare_value("csr_save_if_o", 32'(irq_trap), 32'(csr_save_if_i));
      compare_value("csr_save_id_o", 32'(exc_trap), 32'(csr_save_id_i));
      compare_value("csr_restore_mret_id_o", 32'(mret_ret), 32'(csr_restore_mret_i));
      compare_value("nmi_mode_o", 32'(nmi_exp), 32'(nmi_mode_i));
      // trap and return both leave from flush
      if (exc_trap || mret_ret) begin
        compare_value("flush_id_o", 32'd1, 32'(flush_id_i));
      end
      if (stall_id_i) begin
        // a stalled ID stage must never report ready
        if (id_in_ready_i) begin
          $display("test %0d: ID stage reports ready while stalled", cur_test);
          test_errs++;
          errs++;
        end
        // stall keeps the instruction unless ID is flushed
        if (!(exc_trap || mret_ret)) begin
          compare_value("instr_valid_clear_o", 32'd0, 32'(instr_valid_clear_i));
        end
      end
      // reference state for the next row
      boot_next = !fetch_on && fetch_enable_i;
      if (fetch_enable_i) begin
        fetch_on = 1'b1;
      end
      // NMI mode follows NMI entry and mret by one cycle
      if (irq_trap && (exp_cause_i == EXC_CAUSE_IRQ_NM)) begin
        nmi_exp = 1'b1;
      end else if (mret_ret) begin
        nmi_exp = 1'b0;
      end
    end else if (done_i && !summary_done) begin
      close_test();
      $display("%0d tests passed, %0d tests failed, %0d mismatches",
               tests_ok, tests_bad, errs);
      summary_done = 1'b1;
    end
  end

endmodule

/* test/core_ctrl_props.sv */
////////////////////////////////////////////////////////////
// concurrent properties of the sequencing FSM
////////////////////////////////////////////////////////////

module core_ctrl_props
  import ctrl_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input ctrl_state_e state_q,
  input logic        pc_set_o,
  input logic        in_flush_o,
  input logic        id_in_ready_o,
  input logic        irq_enter_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // sleep is only ever reached through wait sleep
  a_sleep_via_wait: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == SLEEP) |-> ($past(state_q) inside {WAIT_SLEEP, SLEEP}))
    else $error("sleep entered without passing through wait sleep");

  // a redirect out of flush must come straight from decode
  a_flush_from_decode: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_o && in_flush_o) |-> ($past(state_q) == DECODE))
    else $error("flush redirect not preceded by decode");

  // ID must not accept while the interrupt is entered
  a_no_ready_on_irq: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(id_in_ready_o && irq_enter_o))
    else $error("ID ready during interrupt entry");

endmodule

bind ctrl_fsm core_ctrl_props i_core_ctrl_props (
  .clk_i        (clk_i),
  .rst_ni       (rst_ni),
  .state_q      (state_q),
  .pc_set_o     (pc_set_o),
  .in_flush_o   (in_flush_o),
  .id_in_ready_o(id_in_ready_o),
  .irq_enter_o  (irq_enter_o)
);

/* test/core_ctrl_tb.sv */
////////////////////////////////////////////////////////////
// testbench of the machine-mode controller
// replays a cycle trace and checks the control outputs
////////////////////////////////////////////////////////////

module core_ctrl_tb
  import ctrl_pkg::*;
  import trap_pkg::*;
;

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  logic [19:0] ctrl = '0;
  logic [31:0] instr = '0;
  logic [31:0] pc = '0;
  logic [15:0] fast = '0;

  // expected values of the current row
  logic        exp_pc_set = 1'b0;
  logic [1:0]  exp_pc_mux = '0;
  logic [6:0]  exp_cause = '0;
  logic [31:0] exp_mtval = '0;
  logic        exp_busy = 1'b0;
  logic        exp_save_cause = 1'b0;

  logic valid = 1'b0;
  logic done = 1'b0;
  int   test_num = 0;
  int   err_count;
  int   cycles = 0;
  int   cycle_limit = 0;

  logic        ctrl_busy, instr_req, pc_set, id_in_ready, instr_valid_clear, flush_id;
  logic        csr_save_if, csr_save_id, csr_restore_mret_id, csr_save_cause, nmi_mode;
  pc_sel_e     pc_mux;
  exc_pc_sel_e exc_pc_mux;
  exc_cause_e  exc_cause;
  word_t       csr_mtval;

  core_ctrl #(
    .NrFastIrq(16)
  ) i_core_ctrl (
    .clk_i                (clk),
    .rst_ni               (rst_n),
    .fetch_enable_i       (ctrl[0]),
    .ctrl_busy_o          (ctrl_busy),
    .instr_valid_i        (ctrl[1]),
    .illegal_insn_i       (ctrl[2]),
    .ecall_insn_i         (ctrl[3]),
    .ebrk_insn_i          (ctrl[4]),
    .mret_insn_i          (ctrl[5]),
    .wfi_insn_i           (ctrl[6]),
    .csr_pipe_flush_i     (ctrl[19]),
    .instr_fetch_err_i    (ctrl[7]),
    .instr_i              (instr),
    .pc_id_i              (pc),
    .branch_set_i         (ctrl[8]),
    .jump_set_i           (ctrl[9]),
    .stall_id_i           (ctrl[10]),
    .priv_mode_i          (ctrl[11] ? PRIV_LVL_U : PRIV_LVL_M),
    .csr_mstatus_tw_i     (ctrl[12]),
    .csr_mstatus_mie_i    (ctrl[13]),
    .irq_pending_i        (ctrl[14]),
    .irq_nm_i             (ctrl[15]),
    .irq_fast_i           (fast),
    .irq_external_i       (ctrl[16]),
    .irq_software_i       (ctrl[17]),
    .irq_timer_i          (ctrl[18]),
    .nmi_mode_o           (nmi_mode),
    .instr_req_o          (instr_req),
    .pc_set_o             (pc_set),
    .pc_mux_o             (pc_mux),
    .exc_pc_mux_o         (exc_pc_mux),
    .id_in_ready_o        (id_in_ready),
    .instr_valid_clear_o  (instr_valid_clear),
    .flush_id_o           (flush_id),
    .exc_cause_o          (exc_cause),
    .csr_save_if_o        (csr_save_if),
    .csr_save_id_o        (csr_save_id),
    .csr_restore_mret_id_o(csr_restore_mret_id),
    .csr_save_cause_o     (csr_save_cause),
    .csr_mtval_o          (csr_mtval)
  );

  ctrl_checker i_ctrl_checker (
    .clk_i              (clk),
    .valid_i            (valid),
    .done_i             (done),
    .test_i             (test_num),
    .fetch_enable_i     (ctrl[0]),
    .stall_id_i         (ctrl[10]),
    .exp_pc_set_i       (exp_pc_set),
    .exp_pc_mux_i       (exp_pc_mux),
    .exp_cause_i        (exp_cause),
    .exp_mtval_i        (exp_mtval),
    .exp_busy_i         (exp_busy),
    .exp_save_cause_i   (exp_save_cause),
    .pc_set_i           (pc_set),
    .pc_mux_i           (pc_mux),
    .exc_pc_mux_i       (exc_pc_mux),
    .exc_cause_i        (exc_cause),
    .csr_mtval_i        (csr_mtval),
    .ctrl_busy_i        (ctrl_busy),
    .instr_req_i        (instr_req),
    .csr_save_if_i      (csr_save_if),
    .csr_save_id_i      (csr_save_id),
    .csr_restore_mret_i (csr_restore_mret_id),
    .csr_save_cause_i   (csr_save_cause),
    .id_in_ready_i      (id_in_ready),
    .instr_valid_clear_i(instr_valid_clear),
    .flush_id_i         (flush_id),
    .nmi_mode_i         (nmi_mode),
    .err_count_o        (err_count)
  );

  initial begin
    forever #10 clk = ~clk;
  end

  // limit is the trace length plus some slack
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: trace not finished after %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  function automatic bit is_row(input string line);
    return line.len() > 1 && line[0] != 8'h23;
  endfunction

  initial begin
    int    fd;
    int    rows;
    string line;
    rows = 0;
    // first pass only counts rows for the timeout
    fd = $fopen("test/ctrl_trace.txt", "r");
    if (fd == 0) begin
      $display("cannot open trace file test/ctrl_trace.txt");
      $display("Test failures found");
      $finish;
    end else begin
      while ($fgets(line, fd) > 0) begin
        if (is_row(line)) begin
          rows++;
        end
      end
      $fclose(fd);
      cycle_limit = rows + 4 + 50;
      fd = $fopen("test/ctrl_trace.txt", "r");
      repeat (4) @(posedge clk);
      #2 rst_n = 1'b1;
      while ($fgets(line, fd) > 0) begin
        if (is_row(line)) begin
          void'($sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", test_num, ctrl, instr,
                        pc, fast, exp_pc_set, exp_pc_mux, exp_cause, exp_mtval,
                        exp_busy, exp_save_cause));
          valid = 1'b1;
          @(posedge clk);
          #2;
        end
      end
      $fclose(fd);
      valid = 1'b0;
      done  = 1'b1;
      // checker closes the last test on this edge
      @(negedge clk);
      #1;
      if (err_count == 0 && rows > 0) begin
        $display("All tests passed!");
      end else begin
        $display("Test failures found");
      end
      $finish;
    end
  end

endmodule

/* sim.f */
verilog/ctrl_pkg.sv
verilog/trap_pkg.sv
verilog/trap_detect.sv
verilog/irq_arbiter.sv
verilog/ctrl_fsm.sv
verilog/core_ctrl.sv
test/ctrl_checker.sv
test/core_ctrl_props.sv
test/core_ctrl_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f sim.f --top-module core_ctrl_tb \
  -Mdir obj_dir -o core_ctrl_sim || exit 1
out=$(./obj_dir/core_ctrl_sim 2>&1)
echo "$out"
echo "$out" | grep -qF "All tests passed!" && exit 0 || exit 1

/* test/ctrl_trace.txt */
# test ctrl instr pc fast_irq, then expected pc_set pc_mux exc_cause mtval busy save_cause
# ctrl bits 0 fetch_en 1 valid 2 illegal 3 ecall 4 ebrk 5 mret 6 wfi 7 fetch_err 8 branch 9 jump 10 stall 11 umode 12 tw 13 mie 14 pending 15 nmi 16 ext 17 sw 18 timer 19 pipe_flush
1 00000 00000000 00000000 0000 1 0 00 00000000 1 0
1 00000 00000000 00000000 0000 1 0 00 00000000 1 0
1 00001 00000000 00000000 0000 1 0 00 00000000 1 0
1 00001 00000000 00000000 0000 1 0 00 00000000 1 0
1 00001 00000000 00000000 0000 0 0 00 00000000 1 0
1 00001 00000000 00000000 0000 0 1 00 00000000 1 0
2 0008f deadbeef 00001000 0000 0 1 00 00000000 1 0
2 0008f deadbeef 00001000 0000 1 2 01 00001000 1 1
2 00001 00000000 00000000 0000 0 1 00 00000000 1 0
2 00007 12345678 00001004 0000 0 1 00 00000000 1 0
2 00007 12345678 00001004 0000 1 2 02 12345678 1 1
2 00001 00000000 00000000 0000 0 1 00 00000000 1 0
2 0080b 00000073 00001008 0000 0 1 00 00000000 1 0
2 0080b 00000073 00001008 0000 1 2 08 00000000 1 1
2 00001 00000000 00000000 0000 0 1 00 00000000 1 0
3 08001 00000000 00000000 0000 0 1 00 00000000 1 0
3 08001 00000000 00000000 0000 1 2 60 00000000 1 1
3 00001 00000000 00000000 0000 0 1 00 00000000 1 0
3 00023 30200073 00002000 0000 0 1 00 00000000 1 0
3 00023 30200073 00002000 0000 1 3 00 00000000 1 0
3 00001 00000000 00000000 0000 0 1 00 00000000 1 0
3 00823 30200073 00002004 0000 0 1 00 00000000 1 0
3 00823 30200073 00002004 0000 1 2 02 30200073 1 1
3 00001 00000000 00000000 0000 0 1 00 00000000 1 0
4 06001 00000000 00000000 0208 0 1 00 00000000 1 0
4 06001 00000000 00000000 0208 1 2 53 00000000 1 1
4 00001 00000000 00000000 0000 0 1 00 00000000 1 0
4 56001 00000000 00000000 0000 0 1 00 00000000 1 0
4 56001 00000000 00000000 0000 1 2 4b 00000000 1 1
4 00001 00000000 00000000 0000 0 1 00 00000000 1 0
4 08001 00000000 00000000 0000 0 1 00 00000000 1 0
4 08001 00000000 00000000 0000 1 2 60 00000000 1 1
4 08001 00000000 00000000 0000 0 1 00 00000000 1 0
4 08001 00000000 00000000 0000 0 1 00 00000000 1 0
4 08023 30200073 00003000 0000 0 1 00 00000000 1 0
4 08023 30200073 00003000 0000 1 3 00 00000000 1 0
4 08001 00000000 00000000 0000 0 1 00 00000000 1 0
4 08001 00000000 00000000 0000 1 2 60 00000000 1 1
4 00001 00000000 00000000 0000 0 1 00 00000000 1 0
4 00023 30200073 00003004 0000 0 1 00 00000000 1 0
4 00023 30200073 00003004 0000 1 3 00 00000000 1 0
4 00001 00000000 00000000 0000 0 1 00 00000000 1 0
5 00043 10500073 00004000 0000 0 1 00 00000000 1 0
5 00043 10500073 00004000 0000 0 0 00 00000000 1 0
5 00001 00000000 00000000 0000 0 0 00 00000000 0 0
5 00001 00000000 00000000 0000 0 0 00 00000000 0 0
5 00001 00000000 00000000 0000 0 0 00 00000000 0 0
5 04001 00000000 00000000 0000 0 0 00 00000000 1 0
5 00001 00000000 00000000 0000 0 0 00 00000000 1 0
5 00001 00000000 00000000 0000 0 1 00 00000000 1 0
6 46401 00000000 00000000 0000 0 1 00 00000000 1 0
6 46401 00000000 00000000 0000 0 1 00 00000000 1 0
6 46001 00000000 00000000 0000 0 1 00 00000000 1 0
6 46001 00000000 00000000 0000 1 2 47 00000000 1 1
6 00001 00000000 00000000 0000 0 1 00 00000000 1 0
6 00101 00000000 00000000 0000 1 1 00 00000000 1 0
